//--- design/timer_pkg.sv
// Dual timer package
// Widths, vector types and limits shared by the timers and the interrupt combiner
package timer_pkg;

    // Period and counter width
    localparam int TIMER_WIDTH = 16;

    // Smallest period the timer honours, lower values act as this
    localparam int MIN_PERIOD = 2;

    // Expiration counter
    localparam int EVENT_COUNT_WIDTH = 8;
    localparam int EVENT_COUNT_MAX   = 255;

    // One status, mask and clear bit per timer, bit 0 is timer a
    localparam int NUM_TIMERS = 2;

    // Period or counter value
    typedef logic [TIMER_WIDTH-1:0] timer_count_t;

    // Saturating expiration count
    typedef logic [EVENT_COUNT_WIDTH-1:0] event_count_t;

    // Per-timer flags
    typedef logic [NUM_TIMERS-1:0] irq_vec_t;

endpackage

//--- design/period_timer.sv
// Period timer
// Enabled counter that emits a one-cycle expire pulse every period cycles
module period_timer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enable,
    input  timer_pkg::timer_count_t period,
    output logic                    expire
);

    timer_pkg::timer_count_t period_clamped;
    timer_pkg::timer_count_t period_reg;     // Input stage
    timer_pkg::timer_count_t active_period;  // Period of the running interval
    timer_pkg::timer_count_t last_count;     // Counter value on the wrap edge
    timer_pkg::timer_count_t counter;
    logic                    running;        // Set once the load edge has passed
    logic                    wrap;
    logic                    compare_q;      // Compare stage, one ahead of expire

    // Periods of 0 and 1 run as the minimum period
    always_comb begin
        if (period < timer_pkg::timer_count_t'(timer_pkg::MIN_PERIOD)) begin
            period_clamped = timer_pkg::timer_count_t'(timer_pkg::MIN_PERIOD);
        end else begin
            period_clamped = period;
        end
    end

    always_ff @(posedge clk) begin
        period_reg <= period_clamped;
    end

    // Interval restarts at the load edge and on each wrap
    always_ff @(posedge clk) begin
        if (enable && !running) begin
            // First interval takes the period presented with enable
            active_period <= period_clamped;
        end else if (enable && wrap) begin
            active_period <= period_reg;
        end
    end

    assign last_count = active_period - timer_pkg::timer_count_t'(1);
    assign wrap       = running && (counter == last_count);

    // Count state, held at zero while disabled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            counter <= '0;
        end else if (!enable) begin
            running <= 1'b0;
            counter <= '0;
        end else if (!running) begin
            running <= 1'b1;  // Load edge, counting starts next edge
        end else if (wrap) begin
            counter <= '0;
        end else begin
            counter <= counter + timer_pkg::timer_count_t'(1);
        end
    end

    // Compare then pulse
    // Dropping enable flushes both stages so a pending pulse never leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            compare_q <= 1'b0;
            expire    <= 1'b0;
        end else if (!enable) begin
            compare_q <= 1'b0;
            expire    <= 1'b0;
        end else begin
            compare_q <= wrap;
            expire    <= compare_q;  // High for one cycle per interval
        end
    end

endmodule

//--- design/irq_combiner.sv
// Interrupt combiner
// Sticky expire status, masked interrupt and saturating expiration count
module irq_combiner (
    input  logic                    clk,
    input  logic                    rst_n,
    input  timer_pkg::irq_vec_t     expire,
    input  timer_pkg::irq_vec_t     irq_mask,
    input  timer_pkg::irq_vec_t     status_clear,
    input  logic                    count_clear,
    output timer_pkg::irq_vec_t     status,
    output logic                    irq,
    output timer_pkg::event_count_t event_count
);

    // One spare bit to catch the overflow before saturating
    localparam int SUM_WIDTH = timer_pkg::EVENT_COUNT_WIDTH + 1;

    timer_pkg::irq_vec_t     status_next;
    logic                    irq_next;
    logic [SUM_WIDTH-1:0]    pulse_total;  // Pulses seen this cycle
    logic [SUM_WIDTH-1:0]    count_base;
    logic [SUM_WIDTH-1:0]    count_sum;
    timer_pkg::event_count_t count_next;

    // Write one to clear, a pulse on the same edge keeps its bit set
    assign status_next = (status & ~status_clear) | expire;

    // Level follows the status being written, not the old one
    assign irq_next = |(status_next & irq_mask);

    // Both timers may expire in the same cycle
    always_comb begin
        pulse_total = '0;
        for (int i = 0; i < timer_pkg::NUM_TIMERS; i++) begin
            if (expire[i]) begin
                pulse_total = pulse_total + SUM_WIDTH'(1);
            end
        end
    end

    assign count_base = count_clear ? '0 : {1'b0, event_count};  // Clear then add
    assign count_sum  = count_base + pulse_total;

    always_comb begin
        if (count_sum > SUM_WIDTH'(timer_pkg::EVENT_COUNT_MAX)) begin
            count_next = timer_pkg::event_count_t'(timer_pkg::EVENT_COUNT_MAX);
        end else begin
            count_next = count_sum[timer_pkg::EVENT_COUNT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status <= '0;
            irq    <= 1'b0;
        end else begin
            status <= status_next;
            irq    <= irq_next;  // Moves on the same edge as status
        end
    end

    // Saturating expiration counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            event_count <= '0;
        end else begin
            event_count <= count_next;
        end
    end

endmodule

//--- design/dual_timer_top.sv
// Dual interval timer
// Two period timers side by side feeding one interrupt combiner
module dual_timer_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enable_a,
    input  logic                    enable_b,
    input  timer_pkg::timer_count_t period_a,
    input  timer_pkg::timer_count_t period_b,
    input  timer_pkg::irq_vec_t     irq_mask,
    input  timer_pkg::irq_vec_t     status_clear,  // One-cycle strobe per bit
    input  logic                    count_clear,   // One-cycle strobe
    output timer_pkg::irq_vec_t     status,
    output logic                    irq,
    output timer_pkg::event_count_t event_count
);

    // Bit 0 from timer a, bit 1 from timer b
    timer_pkg::irq_vec_t expire_vec;

    period_timer timer_a_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable_a),
        .period (period_a),
        .expire (expire_vec[0])
    );

    period_timer timer_b_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable_b),
        .period (period_b),
        .expire (expire_vec[1])
    );

    // All outputs come from here
    irq_combiner combiner_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .expire       (expire_vec),
        .irq_mask     (irq_mask),
        .status_clear (status_clear),
        .count_clear  (count_clear),
        .status       (status),
        .irq          (irq),
        .event_count  (event_count)
    );

endmodule

//--- bench/tb_dual_timer.sv
// Dual interval timer testbench
// Replays the vectors file through the DUT and checks status, irq and event count
module tb_dual_timer;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD   = 10;
    localparam int    RESET_CYCLES = 3;
    localparam int    IDLE_CYCLES  = 4;   // Enables low between tests
    localparam int    NEWLINE      = 10;
    localparam int    FILE_EOF     = -1;
    localparam string VECTOR_FILE  = "bench/dual_timer_vectors.txt";

    logic                    clk;
    logic                    rst_n;
    logic                    enable_a;
    logic                    enable_b;
    timer_pkg::timer_count_t period_a;
    timer_pkg::timer_count_t period_b;
    timer_pkg::irq_vec_t     irq_mask;
    timer_pkg::irq_vec_t     status_clear;
    logic                    count_clear;
    timer_pkg::irq_vec_t     status;
    logic                    irq;
    timer_pkg::event_count_t event_count;

    // One entry per vectors line
    string test_name_q[$];
    int    enable_a_q[$];
    int    enable_b_q[$];
    int    period_a_q[$];
    int    period_b_q[$];
    int    mask_q[$];
    int    status_clear_q[$];
    int    count_clear_q[$];
    int    cycles_q[$];
    int    exp_status_q[$];
    int    exp_irq_q[$];
    int    exp_count_q[$];

    int error_count = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int watchdog_cycles;
    bit vectors_loaded = 1'b0;

    dual_timer_top dual_timer_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable_a     (enable_a),
        .enable_b     (enable_b),
        .period_a     (period_a),
        .period_b     (period_b),
        .irq_mask     (irq_mask),
        .status_clear (status_clear),
        .count_clear  (count_clear),
        .status       (status),
        .irq          (irq),
        .event_count  (event_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_value(input string test_name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s %s: expected %0d, actual %0d",
                     test_name, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic load_vectors(output bit ok);
        int    fd;
        int    code;
        int    ch;
        int    ena;
        int    enb;
        int    pa;
        int    pb;
        int    mask;
        int    sc;
        int    cc;
        int    cyc;
        int    es;
        int    ei;
        int    ec;
        string token;
        bit    done;

        ok   = 1'b1;
        done = 1'b0;
        fd   = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("cannot open vectors file %s", VECTOR_FILE);
            ok = 1'b0;
        end else begin
            while (!done) begin
                code = $fscanf(fd, "%s", token);
                if (code != 1) begin
                    done = 1'b1;  // End of file
                end else if (token.substr(0, 0) == "#") begin
                    ch = $fgetc(fd);
                    while (ch != NEWLINE && ch != FILE_EOF) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    code = $fscanf(fd, "%d %d %d %d %b %b %d %d %b %d %d",
                                   ena, enb, pa, pb, mask, sc, cc, cyc, es, ei, ec);
                    if (code != 11) begin
                        $display("vectors line for %s is incomplete", token);
                        ok   = 1'b0;
                        done = 1'b1;
                    end else begin
                        test_name_q.push_back(token);
                        enable_a_q.push_back(ena);
                        enable_b_q.push_back(enb);
                        period_a_q.push_back(pa);
                        period_b_q.push_back(pb);
                        mask_q.push_back(mask);
                        status_clear_q.push_back(sc);
                        count_clear_q.push_back(cc);
                        cycles_q.push_back(cyc);
                        exp_status_q.push_back(es);
                        exp_irq_q.push_back(ei);
                        exp_count_q.push_back(ec);
                    end
                end
            end
            $fclose(fd);
        end
        if (test_name_q.size() == 0) begin
            $display("no tests found in %s", VECTOR_FILE);
            ok = 1'b0;
        end
    endtask

    // Twice the total run length plus a margin per test
    function automatic int watchdog_budget();
        int total;

        total = 0;
        foreach (cycles_q[i]) begin
            total += cycles_q[i];
        end
        return 2 * total + 10 * test_name_q.size();
    endfunction

    task automatic run_test(input int idx);
        int    errors_before;
        string name;

        errors_before = error_count;
        name          = test_name_q[idx];

        // DUT sees these from the next edge on
        @(posedge clk);
        enable_a <= (enable_a_q[idx] != 0);
        enable_b <= (enable_b_q[idx] != 0);
        period_a <= timer_pkg::timer_count_t'(period_a_q[idx]);
        period_b <= timer_pkg::timer_count_t'(period_b_q[idx]);
        irq_mask <= timer_pkg::irq_vec_t'(mask_q[idx]);

        repeat (cycles_q[idx]) @(posedge clk);

        // Strobes land on the same edge as the enables dropping
        enable_a     <= 1'b0;
        enable_b     <= 1'b0;
        status_clear <= timer_pkg::irq_vec_t'(status_clear_q[idx]);
        count_clear  <= (count_clear_q[idx] != 0);
        @(posedge clk);
        status_clear <= '0;
        count_clear  <= 1'b0;
        repeat (IDLE_CYCLES - 2) @(posedge clk);

        @(negedge clk);  // Outputs settled after the idle edges
        compare_value(name, "status", exp_status_q[idx], 32'(status));
        compare_value(name, "irq", exp_irq_q[idx], 32'(irq));
        compare_value(name, "event_count", exp_count_q[idx], 32'(event_count));

        if (error_count == errors_before) begin
            pass_count++;
            $display("test %s ok", name);
        end else begin
            fail_count++;
            $display("test %s failed with %0d mismatches", name, error_count - errors_before);
        end
    endtask

    initial begin
        bit load_ok;

        rst_n        <= 1'b0;
        enable_a     <= 1'b0;
        enable_b     <= 1'b0;
        period_a     <= '0;
        period_b     <= '0;
        irq_mask     <= '0;
        status_clear <= '0;
        count_clear  <= 1'b0;

        load_vectors(load_ok);
        if (!load_ok) begin
            $display("Simulation failed");
            $finish;
        end else begin
            watchdog_cycles = watchdog_budget();
            vectors_loaded  = 1'b1;

            repeat (RESET_CYCLES) @(posedge clk);
            rst_n <= 1'b1;

            for (int i = 0; i < test_name_q.size(); i++) begin
                run_test(i);
            end

            $display("%0d tests, %0d passed, %0d failed", test_name_q.size(),
                     pass_count, fail_count);
            if (error_count == 0 && fail_count == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // Watchdog
    initial begin
        wait (vectors_loaded);
        #(watchdog_cycles * CLK_PERIOD);
        $display("watchdog expired after %0d cycles with tests still running",
                 watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- bench/dual_timer_vectors.txt
# name en_a en_b period_a period_b mask status_clear count_clear cycles exp_status exp_irq exp_count
# mask, clears and status in binary with bit 0 for timer a, strobes hit the edge the enables drop
# Reset and timer a alone
reset_idle            0 0   0   0 00 00 0   6   00 0   0
a_period_4            1 0   4   0 00 00 0  22   01 0   5
clear_after_a4        0 0   0   0 00 11 1   2   00 0   0
a_period_0            1 0   0   0 00 00 0  12   01 0   5
clear_after_a0        0 0   0   0 00 11 1   2   00 0   0
a_period_1            1 0   1   0 00 00 0   9   01 0   3
clear_after_a1        0 0   0   0 00 11 1   2   00 0   0
a_period_7            1 0   7   0 00 00 0  30   01 0   4
clear_after_a7        0 0   0   0 00 11 1   2   00 0   0
a_period_5_early      1 0   5   0 00 00 0   6   00 0   0
a_period_5_first      1 0   5   0 00 00 0   7   01 0   1
clear_after_a5        0 0   0   0 00 11 1   2   00 0   0
# Both timers
ab_equal_period_3     1 1   3   3 00 00 0  20   11 0  12
clear_after_equal     0 0   0   0 00 11 1   2   00 0   0
ab_period_3_and_5     1 1   3   5 00 00 0  27   11 0  13
clear_after_mixed     0 0   0   0 00 11 1   2   00 0   0
b_period_6            0 1   0   6 00 00 0  20   10 0   3
# Masking, status carried over from b_period_6
mask_a_hides_b        0 0   0   0 01 00 0   3   10 0   3
mask_b_shows_b        0 0   0   0 10 00 0   3   10 1   3
a_runs_mask_a         1 0   4   0 01 00 0  10   11 1   5
mask_none             0 0   0   0 00 00 0   3   11 0   5
# Write one to clear
clear_b_only          0 0   0   0 11 10 0   3   01 1   5
clear_a_only          0 0   0   0 11 01 0   3   00 0   5
clear_on_a_pulse      1 0   4   0 01 01 0  10   01 1   7
clear_off_a_pulse     1 0   4   0 01 01 0  11   00 0   9
clear_b_on_a_pulse    1 1   3   5 11 10 0  14   01 1  15
clear_ab_on_b_pulse   1 1   3   5 11 11 0  12   10 1  20
count_clear_on_pulse  1 0   2   0 00 11 1  10   01 0   1
clear_all             0 0   0   0 00 11 1   2   00 0   0
# Saturation
saturate_period_2     1 1   2   2 00 00 0 260   11 0 255
saturate_hold         1 0   2   0 00 00 0  20   11 0 255
count_clear_idle      0 0   0   0 00 00 1   2   11 0   0
status_clear_idle     0 0   0   0 00 11 0   2   00 0   0

//--- verilog.f
design/timer_pkg.sv
design/period_timer.sv
design/irq_combiner.sv
design/dual_timer_top.sv
bench/tb_dual_timer.sv

//--- Makefile
# Verilator build and run for the dual interval timer
# Variables can be overridden on the command line, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_dual_timer
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Simulation passed

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR TIMESCALE VFLAGS PASS_TEXT"

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The run passes only if the pass line shows up in the output
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	printf '%s\n' "$$out"; \
	if printf '%s\n' "$$out" | grep -qx "$(PASS_TEXT)"; then \
		echo "make test: pass"; \
	else \
		echo "make test: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
